// File: src/raster_cfg_pkg.sv
// Fixed sizes for the tile rasterizer front end.
// The tile side is 1 << TILE_LOGSIZE pixels.
// The edge pipeline needs EDGE_LATENCY >= 2 (one multiply and one add stage).
// PENDING_BITS covers the edge pipeline plus the single output register.

`default_nettype none

package raster_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data widths

    localparam int DIM_BITS  = 16;  // pixel coordinate
    localparam int PID_BITS  = 8;
    localparam int DATA_BITS = 32;  // signed edge value

    ////////////////////////////////////////////////////////////////////////////
    // tile and pipeline

    localparam int TILE_LOGSIZE = 5;
    localparam int TILE_SIZE    = 1 << TILE_LOGSIZE;
    localparam int EDGE_LATENCY = 3;

    // in flight: every pipeline stage plus the output register
    localparam int PENDING_BITS = $clog2(EDGE_LATENCY + 2);

    ////////////////////////////////////////////////////////////////////////////
    // configuration registers

    localparam int DCR_ADDR_BITS = 4;
    localparam int DCR_DATA_BITS = 32;

    localparam logic [DCR_ADDR_BITS-1:0] DCR_DST_XMIN = 'd0;
    localparam logic [DCR_ADDR_BITS-1:0] DCR_DST_XMAX = 'd1;
    localparam logic [DCR_ADDR_BITS-1:0] DCR_DST_YMIN = 'd2;
    localparam logic [DCR_ADDR_BITS-1:0] DCR_DST_YMAX = 'd3;

endpackage

`default_nettype wire

// File: src/raster_types_pkg.sv
// Types shared by the rasterizer front end and its testbench.
// Edge values are signed two's complement and wrap at DATA_BITS.
// Coordinates are unsigned pixel positions of the tile origin.

`default_nettype none

package raster_types_pkg;

    import raster_cfg_pkg::*;

    typedef logic [DIM_BITS-1:0]         dim_t;
    typedef logic [PID_BITS-1:0]         pid_t;
    typedef logic signed [DATA_BITS-1:0] edge_val_t;

    typedef logic [DCR_ADDR_BITS-1:0] dcr_addr_t;
    typedef logic [DCR_DATA_BITS-1:0] dcr_data_t;

    // edge function e(x, y) = a*x + b*y + c
    typedef struct packed {
        edge_val_t a;
        edge_val_t b;
        edge_val_t c;
    } edge_t;

    typedef edge_t [2:0] edges_t;

    typedef struct packed {
        dim_t   xloc;   // tile origin
        dim_t   yloc;
        pid_t   pid;
        edges_t edges;
    } prim_t;

    typedef edge_val_t [2:0] extents_t;

    // edge pipeline result
    typedef struct packed {
        prim_t           prim;
        extents_t        extents;
        edge_val_t [2:0] evals;  // e(xloc, yloc) per edge
    } eval_t;

    typedef struct packed {
        dim_t xmin;
        dim_t xmax;
        dim_t ymin;
        dim_t ymax;
    } scissor_t;

    typedef struct packed {
        logic   done;
        dim_t   xloc;
        dim_t   yloc;
        pid_t   pid;
        edges_t edges;  // c holds the value at the tile origin
    } tile_out_t;

endpackage

`default_nettype wire

// File: src/raster_dcr.sv
// Write-only configuration registers for the scissor rectangle.
// Only the low DIM_BITS of the write data are kept; unknown addresses are ignored.
// A write is visible on scissor one cycle after the strobe.
// Reset opens the scissor to the full coordinate range.

`timescale 1ns/1ps
`default_nettype none

module raster_dcr import raster_cfg_pkg::*; import raster_types_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  logic      dcr_write_valid,
    input  dcr_addr_t dcr_write_addr,
    input  dcr_data_t dcr_write_data,

    output scissor_t  scissor
);

    dim_t wr_value;

    assign wr_value = dcr_write_data[DIM_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            scissor.xmin <= '0;
            scissor.xmax <= '1;
            scissor.ymin <= '0;
            scissor.ymax <= '1;
        end else if (dcr_write_valid) begin
            case (dcr_write_addr)
                DCR_DST_XMIN: scissor.xmin <= wr_value;
                DCR_DST_XMAX: scissor.xmax <= wr_value;
                DCR_DST_YMIN: scissor.ymin <= wr_value;
                DCR_DST_YMAX: scissor.ymax <= wr_value;
                default: ;  // unmapped
            endcase
        end
    end

    // a write with an undefined address would leave the rectangle unknown
    a_dcr_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        dcr_write_valid |-> !$isunknown(dcr_write_addr)
    ) else $error("dcr write with unknown address");

endmodule

`default_nettype wire

// File: src/raster_edge_eval.sv
// Edge function and extent pipeline, EDGE_LATENCY stages deep.
// Stage 0 registers the products, stage 1 the sums, later stages only delay.
// The whole pipeline stalls when its last stage is valid and cull_ready is low.
// Arithmetic wraps at DATA_BITS; coordinates are taken as unsigned.

`timescale 1ns/1ps
`default_nettype none

module raster_edge_eval import raster_cfg_pkg::*; import raster_types_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    input  logic  in_valid,
    input  prim_t in_prim,
    output logic  in_ready,

    output logic  eval_valid,
    output eval_t eval_data,
    input  logic  cull_ready
);

    logic stall;
    logic advance;

    logic [EDGE_LATENCY-1:0] valid_q;

    // side pipe, shares the enable of the arithmetic
    prim_t    prim_q [EDGE_LATENCY];
    extents_t ext_q  [EDGE_LATENCY];

    edge_val_t [2:0] prod_ax;  // stage 0
    edge_val_t [2:0] prod_by;
    edge_val_t [2:0] c_q;
    edge_val_t [2:0] val_q [EDGE_LATENCY-1];  // stage 1 and up

    edge_val_t xloc_s;
    edge_val_t yloc_s;
    extents_t  in_ext;

    function automatic edge_val_t pos_part(input edge_val_t v);
        return (v < 0) ? '0 : v;
    endfunction

    assign stall    = valid_q[EDGE_LATENCY-1] && !cull_ready;
    assign advance  = !stall;
    assign in_ready = advance;

    assign xloc_s = edge_val_t'(in_prim.xloc);  // zero extended
    assign yloc_s = edge_val_t'(in_prim.yloc);

    // worst case growth of each edge across the tile
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            in_ext[i] = (pos_part(in_prim.edges[i].a) + pos_part(in_prim.edges[i].b))
                        << TILE_LOGSIZE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[EDGE_LATENCY-2:0], in_valid};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // datapath

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < 3; i++) begin
                prod_ax[i]  <= in_prim.edges[i].a * xloc_s;
                prod_by[i]  <= in_prim.edges[i].b * yloc_s;
                c_q[i]      <= in_prim.edges[i].c;
                val_q[0][i] <= prod_ax[i] + prod_by[i] + c_q[i];
            end
            for (int j = 1; j < EDGE_LATENCY - 1; j++) begin
                val_q[j] <= val_q[j-1];
            end

            prim_q[0] <= in_prim;
            ext_q[0]  <= in_ext;
            for (int j = 1; j < EDGE_LATENCY; j++) begin
                prim_q[j] <= prim_q[j-1];
                ext_q[j]  <= ext_q[j-1];
            end
        end
    end

    assign eval_valid = valid_q[EDGE_LATENCY-1];
    assign eval_data  = '{
        prim:    prim_q[EDGE_LATENCY-1],
        extents: ext_q[EDGE_LATENCY-1],
        evals:   val_q[EDGE_LATENCY-2]
    };

    // the cull stage may sample eval_data on any cycle of a stall
    a_eval_hold: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> eval_valid && $stable(eval_data)
    ) else $error("edge pipeline output changed while stalled");

endmodule

`default_nettype wire

// File: src/raster_tile_cull.sv
// Tile rejection and the registered output stage.
// A tile is dropped when any edge value plus extent is negative or it misses the
// scissor; scissor compares are unsigned, the tile far edge is computed without wrap.
// The done record is a level taken from the done input while the register is
// empty. Only tile records follow the hold rule of the output stream.

`timescale 1ns/1ps
`default_nettype none

module raster_tile_cull import raster_cfg_pkg::*; import raster_types_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  logic      eval_valid,
    input  eval_t     eval_data,
    output logic      cull_ready,

    input  scissor_t  scissor,
    input  logic      done,
    output logic      retire,

    output logic      out_valid,
    output tile_out_t out_tile,
    input  logic      out_ready
);

    logic            tile_valid;
    tile_out_t       tile_q;
    tile_out_t       tile_next;

    edge_val_t [2:0] reach;
    logic            edge_miss;
    logic            scissor_miss;
    logic [DIM_BITS:0] x_end;  // one bit wider, no wrap
    logic [DIM_BITS:0] y_end;

    logic keep;
    logic accept;
    logic send;
    logic drop;
    logic retire_owed;

    ////////////////////////////////////////////////////////////////////////////
    // rejection tests

    always_comb begin
        edge_miss = 1'b0;
        for (int i = 0; i < 3; i++) begin
            reach[i] = eval_data.evals[i] + eval_data.extents[i];
            if (reach[i] < 0) begin
                edge_miss = 1'b1;  // whole tile outside this edge
            end
        end
    end

    assign x_end = {1'b0, eval_data.prim.xloc} + (DIM_BITS+1)'(TILE_SIZE);
    assign y_end = {1'b0, eval_data.prim.yloc} + (DIM_BITS+1)'(TILE_SIZE);

    assign scissor_miss = (eval_data.prim.xloc >= scissor.xmax)
                       || (eval_data.prim.yloc >= scissor.ymax)
                       || (x_end <= {1'b0, scissor.xmin})
                       || (y_end <= {1'b0, scissor.ymin});

    assign keep = !edge_miss && !scissor_miss;

    ////////////////////////////////////////////////////////////////////////////
    // output register

    assign cull_ready = !tile_valid || out_ready;
    assign accept     = eval_valid && cull_ready;
    assign send       = tile_valid && out_ready;
    assign drop       = accept && !keep;

    always_comb begin
        tile_next.done = 1'b0;
        tile_next.xloc = eval_data.prim.xloc;
        tile_next.yloc = eval_data.prim.yloc;
        tile_next.pid  = eval_data.prim.pid;
        for (int i = 0; i < 3; i++) begin
            tile_next.edges[i].a = eval_data.prim.edges[i].a;
            tile_next.edges[i].b = eval_data.prim.edges[i].b;
            tile_next.edges[i].c = eval_data.evals[i];  // value at the origin
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tile_valid <= 1'b0;
        end else if (cull_ready) begin
            tile_valid <= accept && keep;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && keep) begin
            tile_q <= tile_next;
        end
    end

    // a drop and a send in one cycle give two retires; the second one
    // goes out next cycle, the register is empty then so no new send comes
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_owed <= 1'b0;
        end else begin
            retire_owed <= (send && drop) || (retire_owed && (send || drop));
        end
    end

    assign retire = send || drop || retire_owed;

    always_comb begin
        out_tile      = '0;
        out_tile.done = done;
        if (tile_valid) begin
            out_tile = tile_q;
        end
    end

    assign out_valid = tile_valid || done;

    a_out_hold: assert property (
        @(posedge clk) disable iff (reset)
        tile_valid && !out_ready |=> out_valid && $stable(out_tile)
    ) else $error("output tile changed while held");

endmodule

`default_nettype wire

// File: src/raster_unit.sv
// Top level of the tile rasterizer front end: one primitive per tile in,
// surviving tiles out in order, with c replaced by the edge value at the origin.
// With out_ready high a kept tile leaves EDGE_LATENCY + 1 cycles after its input.
// out_valid with done set means nothing is in flight; it is a level, not a tile.

`timescale 1ns/1ps
`default_nettype none

module raster_unit import raster_cfg_pkg::*; import raster_types_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // configuration, no handshake
    input  logic      dcr_write_valid,
    input  dcr_addr_t dcr_write_addr,
    input  dcr_data_t dcr_write_data,

    input  logic      in_valid,
    input  prim_t     in_prim,
    output logic      in_ready,

    output logic      out_valid,
    output tile_out_t out_tile,
    input  logic      out_ready
);

    scissor_t scissor;

    logic  eval_valid;
    eval_t eval_data;
    logic  cull_ready;
    logic  retire;

    logic                    in_fire;
    logic [PENDING_BITS-1:0] pending;  // tiles in flight
    logic                    done;

    raster_dcr dcr (
        .clk             (clk),
        .reset           (reset),
        .dcr_write_valid (dcr_write_valid),
        .dcr_write_addr  (dcr_write_addr),
        .dcr_write_data  (dcr_write_data),
        .scissor         (scissor)
    );

    raster_edge_eval edge_eval (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_prim    (in_prim),
        .in_ready   (in_ready),
        .eval_valid (eval_valid),
        .eval_data  (eval_data),
        .cull_ready (cull_ready)
    );

    raster_tile_cull tile_cull (
        .clk        (clk),
        .reset      (reset),
        .eval_valid (eval_valid),
        .eval_data  (eval_data),
        .cull_ready (cull_ready),
        .scissor    (scissor),
        .done       (done),
        .retire     (retire),
        .out_valid  (out_valid),
        .out_tile   (out_tile),
        .out_ready  (out_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // in-flight tracking

    assign in_fire = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= pending + PENDING_BITS'(in_fire) - PENDING_BITS'(retire);
        end
    end

    assign done = (pending == '0);

    // every retire must match an earlier input transfer
    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset)
        retire |-> pending != '0
    ) else $error("in-flight counter underflow");

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
// Clock and reset source for the testbench.
// Reset is synchronous, high for RESET_CYCLES rising edges, released on a falling edge.

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter realtime PERIOD       = 40ns,
    parameter int      RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/raster_unit_tb.sv
// Testbench for raster_unit. Inputs change on the falling edge and outputs are
// sampled 1 ns later, so a handshake seen there happens at the next rising edge.
// Config writes are only issued with the pipeline drained.

`timescale 1ns/1ps
`default_nettype none

module raster_unit_tb import raster_cfg_pkg::*; import raster_types_pkg::*; ();

    typedef struct {
        bit        is_cfg;
        dcr_addr_t addr;
        dcr_data_t data;
        prim_t     prim;
        bit        keep;  // expected decision
    } row_t;

    logic      clk;
    logic      reset;
    logic      dcr_write_valid;
    dcr_addr_t dcr_write_addr;
    dcr_data_t dcr_write_data;
    logic      in_valid;
    prim_t     in_prim;
    logic      in_ready;
    logic      out_valid;
    tile_out_t out_tile;
    logic      out_ready;

    row_t      rows[$];
    tile_out_t exp_q[$];
    scissor_t  model_sc;
    logic [31:0] lcg_state = 32'h38e6;
    bit        ready_mode;  // out_ready held high when set
    bit        hold_prev;
    tile_out_t held;
    int        cyc;
    int        last_out_cyc;

    tb_clock #(.PERIOD(40ns), .RESET_CYCLES(10)) clock_gen (.clk(clk), .reset(reset));

    raster_unit u_dut (
        .clk(clk), .reset(reset),
        .dcr_write_valid(dcr_write_valid), .dcr_write_addr(dcr_write_addr),
        .dcr_write_data(dcr_write_data),
        .in_valid(in_valid), .in_prim(in_prim), .in_ready(in_ready),
        .out_valid(out_valid), .out_tile(out_tile), .out_ready(out_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic timeout(input string what);
        $display("timeout while waiting for %s at t=%0t", what, $time);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    function automatic edge_val_t pos(input edge_val_t v);
        return (v > 0) ? v : 0;
    endfunction

    // reference decision from the edge and scissor rules
    function automatic bit model_keep(input prim_t p, input scissor_t s);
        edge_val_t v;
        edge_val_t ext;
        bit        k;
        k = 1;
        for (int i = 0; i < 3; i++) begin
            v   = p.edges[i].a * edge_val_t'(p.xloc) + p.edges[i].b * edge_val_t'(p.yloc)
                  + p.edges[i].c;
            ext = (pos(p.edges[i].a) + pos(p.edges[i].b)) << 5;
            if (v + ext < 0) k = 0;
        end
        if (p.xloc >= s.xmax || p.yloc >= s.ymax) k = 0;
        if (int'(p.xloc) + 32 <= int'(s.xmin) || int'(p.yloc) + 32 <= int'(s.ymin)) k = 0;
        return k;
    endfunction

    function automatic tile_out_t model_tile(input prim_t p);
        tile_out_t t;
        t.done  = 1'b0;
        t.xloc  = p.xloc;
        t.yloc  = p.yloc;
        t.pid   = p.pid;
        t.edges = p.edges;
        for (int i = 0; i < 3; i++) begin
            t.edges[i].c = p.edges[i].a * edge_val_t'(p.xloc)
                         + p.edges[i].b * edge_val_t'(p.yloc) + p.edges[i].c;
        end
        return t;
    endfunction

    task automatic add_prim(input int x, input int y, input int pid, input int a0, input int b0,
                            input int c0, input int a1, input int b1, input int c1,
                            input int a2, input int b2, input int c2, input bit keep);
        row_t r;
        r = '{is_cfg: 0, addr: '0, data: '0, prim: '0, keep: keep};
        r.prim.xloc = dim_t'(x);
        r.prim.yloc = dim_t'(y);
        r.prim.pid  = pid_t'(pid);
        r.prim.edges[0] = '{a0, b0, c0};
        r.prim.edges[1] = '{a1, b1, c1};
        r.prim.edges[2] = '{a2, b2, c2};
        rows.push_back(r);
    endtask

    task automatic add_cfg(input dcr_addr_t addr, input int data);
        row_t r;
        r = '{is_cfg: 1, addr: addr, data: dcr_data_t'(data), prim: '0, keep: 0};
        rows.push_back(r);
    endtask

    // drive at the falling edge and check what the next rising edge takes
    task automatic cycle(input bit v, input prim_t p, input bit wv, input dcr_addr_t wa,
                         input dcr_data_t wd, output bit fired);
        tile_out_t e;
        @(negedge clk);
        in_valid        = v;
        in_prim         = p;
        dcr_write_valid = wv;
        dcr_write_addr  = wa;
        dcr_write_data  = wd;
        lcg_state       = lcg_next(lcg_state);
        out_ready       = ready_mode ? 1'b1 : (lcg_state[18:17] != 2'b00);
        #1;
        cyc++;
        if (hold_prev) begin
            check("out_tile held", {63'd0, out_valid && out_tile == held}, 64'd1);
        end
        if (exp_q.size() != 0) begin
            check("out_tile.done", {63'd0, out_valid && out_tile.done}, 64'd0);
        end
        if (out_valid && out_tile.done) begin
            check("out_tile.xloc", 64'(out_tile.xloc), 64'd0);
            check("out_tile.yloc", 64'(out_tile.yloc), 64'd0);
            check("out_tile.pid", 64'(out_tile.pid), 64'd0);
            check("out_tile.edges", {63'd0, |out_tile.edges}, 64'd0);
        end
        hold_prev = 0;
        if (out_valid && !out_tile.done) begin
            if (!out_ready) begin
                hold_prev = 1;
                held      = out_tile;
            end else begin
                if (exp_q.size() == 0) begin
                    $display("a tile came out that was not expected at t=%0t", $time);
                    $display("STATUS: FAIL");
                    $fatal(1);
                end
                e = exp_q.pop_front();
                check("out_tile.xloc", 64'(out_tile.xloc), 64'(e.xloc));
                check("out_tile.yloc", 64'(out_tile.yloc), 64'(e.yloc));
                check("out_tile.pid", 64'(out_tile.pid), 64'(e.pid));
                for (int i = 0; i < 3; i++) begin
                    check($sformatf("out_tile.edges[%0d].a", i), 64'(out_tile.edges[i].a),
                          64'(e.edges[i].a));
                    check($sformatf("out_tile.edges[%0d].b", i), 64'(out_tile.edges[i].b),
                          64'(e.edges[i].b));
                    check($sformatf("out_tile.edges[%0d].c", i), 64'(out_tile.edges[i].c),
                          64'(e.edges[i].c));
                end
                last_out_cyc = cyc;
            end
        end
        fired = v && in_ready;
        if (fired) begin
            check("model keep", {63'd0, model_keep(p, model_sc)}, {63'd0, rows_keep(p)});
            if (model_keep(p, model_sc)) exp_q.push_back(model_tile(p));
        end
    endtask

    // expected decision of the table row that carries this primitive
    function automatic bit rows_keep(input prim_t p);
        foreach (rows[i]) begin
            if (!rows[i].is_cfg && rows[i].prim == p) return rows[i].keep;
        end
        return 0;
    endfunction

    task automatic send_prim(input prim_t p, output int fire_cyc);
        bit fired;
        int n;
        n = 0;
        fired = 0;
        while (!fired) begin
            cycle(1'b1, p, 1'b0, '0, '0, fired);
            n++;
            if (n > 200) timeout("in_ready");
        end
        fire_cyc = cyc;
    endtask

    // idle until every tile is out and the done record shows
    task automatic drain();
        bit fired;
        int n;
        n = 0;
        do begin
            cycle(1'b0, '0, 1'b0, '0, '0, fired);
            n++;
            if (n > 500) timeout("the done record");
        end while (exp_q.size() != 0 || !(out_valid && out_tile.done));
    endtask

    initial begin
        bit fired;
        int fc;
        int n;
        dcr_write_valid = 0;
        dcr_write_addr  = '0;
        dcr_write_data  = '0;
        in_valid        = 0;
        in_prim         = '0;
        out_ready       = 0;
        model_sc        = '{xmin: 16'd0, xmax: 16'hFFFF, ymin: 16'd0, ymax: 16'hFFFF};
        hold_prev       = 0;
        cyc             = 0;

        ///////////////////////////////////////////////////////////////////////////
        // table

        add_prim(64, 32, 1, 1, 1, 0, 1, 1, 0, 1, 1, 0, 1);
        add_prim(64, 32, 2, -1, 0, 10, 1, 1, 0, 1, 1, 0, 0);     // edge 0 outside
        add_prim(64, 32, 3, 1, 0, -90, 0, 1, 0, 1, 1, 0, 1);      // just inside
        add_prim(64, 32, 4, 1, 0, -100, 0, 1, 0, 1, 1, 0, 0);
        add_prim(96, 64, 5, 2, -3, 5, 3, 5, -7, 0, 0, 1, 1);
        add_prim(32, 0, 6, 0, 0, 1, 0, 0, 1, 0, 0, -1, 0);
        add_cfg(DCR_DST_XMIN, 100);
        add_cfg(DCR_DST_XMAX, 200);
        add_cfg(DCR_DST_YMIN, 50);
        add_cfg(DCR_DST_YMAX, 150);
        add_prim(68, 64, 7, 3, 5, -7, 3, 5, -7, 3, 5, -7, 0);     // right edge at xmin
        add_prim(96, 64, 8, 3, 5, -7, 3, 5, -7, 3, 5, -7, 1);
        add_prim(200, 64, 9, 3, 5, -7, 3, 5, -7, 3, 5, -7, 0);
        add_prim(192, 64, 10, 3, 5, -7, 3, 5, -7, 3, 5, -7, 1);
        add_prim(96, 150, 11, 3, 5, -7, 3, 5, -7, 3, 5, -7, 0);
        add_prim(96, 18, 12, 3, 5, -7, 3, 5, -7, 3, 5, -7, 0);
        add_prim(96, 19, 13, 3, 5, -7, 3, 5, -7, 3, 5, -7, 1);    // one pixel row
        add_prim(128, 118, 14, 3, 5, -7, 3, 5, -7, 3, 5, -7, 1);
        add_prim(160, 96, 15, -2, 1, 500, 3, 5, -7, 1, 1, 0, 1);

        n = 0;
        do begin
            @(negedge clk);
            #1;
            n++;
            if (n > 50) timeout("reset release");
        end while (reset);
        check("out_valid after reset", {63'd0, out_valid}, 64'd1);
        check("out_tile.done after reset", {63'd0, out_tile.done}, 64'd1);

        // latency with out_ready held high
        ready_mode = 1;
        send_prim(rows[0].prim, fc);
        n = 0;
        while (exp_q.size() != 0) begin
            cycle(1'b0, '0, 1'b0, '0, '0, fired);
            n++;
            if (n > 50) timeout("the first tile");
        end
        check("output latency", 64'(last_out_cyc - fc), 64'(EDGE_LATENCY + 1));
        drain();

        // whole table under random back-pressure
        ready_mode = 0;
        foreach (rows[i]) begin
            if (rows[i].is_cfg) begin
                drain();
                cycle(1'b0, '0, 1'b1, rows[i].addr, rows[i].data, fired);
                case (rows[i].addr)
                    DCR_DST_XMIN: model_sc.xmin = dim_t'(rows[i].data);
                    DCR_DST_XMAX: model_sc.xmax = dim_t'(rows[i].data);
                    DCR_DST_YMIN: model_sc.ymin = dim_t'(rows[i].data);
                    default:      model_sc.ymax = dim_t'(rows[i].data);
                endcase
            end else begin
                send_prim(rows[i].prim, fc);
            end
        end
        drain();

        if (exp_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("tiles still missing at the end of the run");
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: sim.f
src/raster_cfg_pkg.sv
src/raster_types_pkg.sv
src/raster_dcr.sv
src/raster_edge_eval.sv
src/raster_tile_cull.sv
src/raster_unit.sv
sim/tb_clock.sv
sim/raster_unit_tb.sv

// File: Makefile
# Verilator build and run of the rasterizer front end testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= raster_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
